// File: tests/read_engine_cases.txt
# base(hex) size(elements) shared(1)/non-alloc(0) batch_limit resp_delay stall_pct
# one read job per line
0000000000001000 64 1 4 2 0
0000000000002000 100 0 4 3 0
0000000000003000 1 0 2 0 0
0000000000004000 1 1 2 0 0
0000000000005000 70 0 1 2 0
0000000000006000 90 0 64 1 20
0000000000007000 33 0 3 5 30
000000000000a000 500 1 8 4 40
0000000100000000 256 0 5 0 25
00000000ffffff80 48 0 2 1 10
0000000000008000 17 0 4 0 50
0000000000009000 9 0 4 2 0
000000000000b000 5 0 3 1 0
000000000000c000 31 0 2 0 15
000000000000d000 32 0 2 3 0
0000000200000000 1000 1 16 6 15
000000000000e000 200 0 1 0 0
000000000000f000 2 0 1 4 0
0000000000010000 65 0 2 8 35
0000000000011000 128 1 4 10 0
0000000000012000 3 0 8 0 20
0000000000013000 400 0 7 3 45

// File: read_engine_top.f
+incdir+rtl
rtl/read_engine_pkg.sv
rtl/read_stream_fsm.sv
rtl/read_batch_counter.sv
rtl/read_command_gen.sv
rtl/read_engine_top.sv
tests/read_engine_checker.sv
tests/read_engine_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the read engine testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
	--top-module read_engine_tb \
	-f read_engine_top.f \
	--Mdir obj_dir \
	-o read_engine_sim

output="$(./obj_dir/read_engine_sim)"
echo "$output"

if grep -Fxq "Finished with no errors" <<< "$output"; then
	echo "simulation passed"
	exit 0
else
	echo "simulation failed"
	exit 1
fi

// File: tests/read_engine_tb.sv
//////////////////////////////
// read engine testbench
// reads jobs from the case file, runs the
// req/ack handshake, models responses and
// random back-pressure, bounds the run
//////////////////////////////

`timescale 1ns/1ps

`include "read_engine_defines.svh"

module read_engine_tb;

	import read_engine_pkg::*;

	localparam int MAX_CASES = 64;

	logic                clock;
	logic                rstn;
	logic                job_req;
	read_job_t           job;
	logic                shared_mode;
	logic [`CNT_W-1:0]   batch_limit;
	logic                cmd_alfull = 1'b0;
	read_resp_t          resp = '0;
	logic                job_ack;
	read_cmd_t           cmd;
	logic [`SIZE_W-1:0]  words_done;

	// case table
	logic [`ADDR_W-1:0]  case_base [MAX_CASES];
	logic [`SIZE_W-1:0]  case_size [MAX_CASES];
	logic                case_shared [MAX_CASES];
	logic [`CNT_W-1:0]   case_limit [MAX_CASES];
	int                  case_delay [MAX_CASES];
	int                  case_stall [MAX_CASES];
	int                  num_cases = 0;

	int                  cur_delay = 0;
	int                  cur_stall = 0;
	int                  seed = 32'h142ccc55;
	int                  tb_errors = 0;
	int                  timeout_limit = 0;
	int                  watchdog_cycles = 0;
	int                  mismatch_count;
	int                  protocol_count;

	// response model queue
	int                  resp_time = 0;
	logic [`SIZE_W-1:0]  pend_size [$];
	int                  pend_due [$];

	read_engine_top UUT (
		.clock       (clock),
		.rstn        (rstn),
		.job_req     (job_req),
		.job         (job),
		.shared_mode (shared_mode),
		.batch_limit (batch_limit),
		.cmd_alfull  (cmd_alfull),
		.resp        (resp),
		.job_ack     (job_ack),
		.cmd         (cmd),
		.words_done  (words_done)
	);

	read_engine_checker checker_inst (
		.clock          (clock),
		.rstn           (rstn),
		.job_req        (job_req),
		.job_ack        (job_ack),
		.job            (job),
		.shared_mode    (shared_mode),
		.batch_limit    (batch_limit),
		.cmd_alfull     (cmd_alfull),
		.cmd            (cmd),
		.resp           (resp),
		.words_done     (words_done),
		.mismatch_count (mismatch_count),
		.protocol_count (protocol_count)
	);

	initial begin
		clock = 1'b0;
		forever #5 clock = ~clock;
	end

	function automatic int lines_for(input logic [`SIZE_W-1:0] size);
		return int'((size + `SIZE_W'(31)) / `SIZE_W'(32));
	endfunction

	task automatic load_cases();
		int    fd;
		int    n;
		string line;
		fd = $fopen("tests/read_engine_cases.txt", "r");
		if (fd == 0) begin
			$display("ERROR: could not open the case file");
			tb_errors++;
			return;
		end
		while (!$feof(fd)) begin
			line = "";
			n = $fgets(line, fd);
			// skip comment and blank lines
			if (n > 0 && line.len() > 1 && line[0] != "#" && num_cases < MAX_CASES) begin
				n = $sscanf(line, "%h %d %d %d %d %d", case_base[num_cases],
					case_size[num_cases], case_shared[num_cases], case_limit[num_cases],
					case_delay[num_cases], case_stall[num_cases]);
				if (n == 6)
					num_cases++;
			end
		end
		$fclose(fd);
	endtask

	task automatic run_job(input int i);
		@(posedge clock);
		#1;
		job.base    = case_base[i];
		job.size    = case_size[i];
		shared_mode = case_shared[i];
		batch_limit = case_limit[i];
		cur_delay   = case_delay[i];
		cur_stall   = case_stall[i];
		job_req     = 1'b1;
		while (!job_ack) begin
			@(posedge clock);
			#1;
		end
		job_req = 1'b0;
		while (job_ack) begin
			@(posedge clock);
			#1;
		end
	endtask

	task automatic report_counts(input int timeouts);
		$display("error counts: %0d mismatch, %0d protocol, %0d testbench",
			mismatch_count, protocol_count, tb_errors + timeouts);
	endtask

//////////////////////////////
// responses and back-pressure
//////////////////////////////

	// one response per command after the case delay
	always @(posedge clock) begin
		resp_time = resp_time + 1;
		if (cmd.valid) begin
			pend_size.push_back(cmd.real_size);
			pend_due.push_back(resp_time + cur_delay);
		end
		#1;
		if (pend_due.size() > 0 && pend_due[0] <= resp_time) begin
			resp.valid     = 1'b1;
			resp.real_size = pend_size.pop_front();
			void'(pend_due.pop_front());
		end else begin
			resp = '0;
		end
	end

	always @(posedge clock) begin
		#1;
		cmd_alfull = ({$random(seed)} % 100) < cur_stall;
	end

	// cycle bound for the whole run
	initial begin
		@(posedge clock);
		while (watchdog_cycles < timeout_limit) begin
			@(posedge clock);
			watchdog_cycles++;
		end
		$display("ERROR: timeout, jobs not finished within %0d cycles", timeout_limit);
		report_counts(1);
		$display("Finished with errors");
		$finish;
	end

//////////////////////////////
// main sequence
//////////////////////////////

	initial begin
		rstn        = 1'b0;
		job_req     = 1'b0;
		job         = '0;
		shared_mode = 1'b0;
		batch_limit = '0;
		load_cases();
		if (num_cases == 0) begin
			$display("ERROR: no job cases were read");
			tb_errors++;
		end
		timeout_limit = 200;
		for (int i = 0; i < num_cases; i++)
			timeout_limit += lines_for(case_size[i]) * (case_delay[i] + 4) + 20;
		repeat (3) @(posedge clock);
		#1;
		rstn = 1'b1;
		for (int i = 0; i < num_cases; i++)
			run_job(i);
		repeat (4) @(posedge clock);
		#1;
		report_counts(0);
		if (mismatch_count + protocol_count + tb_errors == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

endmodule

// File: tests/read_engine_checker.sv
//////////////////////////////
// read engine checker
// watches the DUT ports and compares the
// command stream, batch depth, back-pressure
// and job completion against the job rules
//////////////////////////////

`timescale 1ns/1ps

`include "read_engine_defines.svh"

module read_engine_checker (
	input  logic                         clock,
	input  logic                         rstn,
	input  logic                         job_req,
	input  logic                         job_ack,
	input  read_engine_pkg::read_job_t   job,
	input  logic                         shared_mode,
	input  logic [`CNT_W-1:0]            batch_limit,
	input  logic                         cmd_alfull,
	input  read_engine_pkg::read_cmd_t   cmd,
	input  read_engine_pkg::read_resp_t  resp,
	input  logic [`SIZE_W-1:0]           words_done,
	output int                           mismatch_count,
	output int                           protocol_count
);

	import read_engine_pkg::*;

	logic [`SIZE_W-1:0]  cmd_idx;
	logic [`SIZE_W-1:0]  n_cmds;
	logic [`SIZE_W-1:0]  exp_real;
	logic [`ADDR_W-1:0]  exp_addr;
	logic [`BYTES_W-1:0] exp_bytes;
	read_opcode_e        exp_op;
	int                  outstanding;
	logic                req_q;
	logic                ack_q;
	logic                alfull_q;

	// cachelines needed for a job, rounded up
	function automatic logic [`SIZE_W-1:0] expected_cmds(input logic [`SIZE_W-1:0] size);
		return (size + `SIZE_W'(`CL_ELEMS - 1)) / `SIZE_W'(`CL_ELEMS);
	endfunction

	// power of two, at least 4, not below the byte count
	function automatic logic [`BYTES_W-1:0] partial_bytes(input logic [`SIZE_W-1:0] count);
		logic [`SIZE_W-1:0] p;
		p = `SIZE_W'(4);
		while (p < count * `SIZE_W'(`ELEM_BYTES))
			p = p << 1;
		return p[`BYTES_W-1:0];
	endfunction

	task automatic report_mismatch(input string name, input logic [63:0] expected,
		input logic [63:0] actual);
		$display("MISMATCH at %0t: %s expected %0h got %0h", $time, name, expected, actual);
		mismatch_count++;
	endtask

	task automatic report_protocol(input string what);
		$display("ERROR at %0t: %s", $time, what);
		protocol_count++;
	endtask

//////////////////////////////
// per-edge comparison
//////////////////////////////

	always @(posedge clock) begin
		if (!rstn) begin
			cmd_idx     = '0;
			outstanding = 0;
			req_q       = 1'b0;
			ack_q       = 1'b0;
			alfull_q    = 1'b0;
		end else begin
			n_cmds = expected_cmds(job.size);
			// new job on the rising request
			if (job_req && !req_q) begin
				cmd_idx     = '0;
				outstanding = 0;
			end
			if (cmd.valid) begin
				if (alfull_q)
					report_protocol("command issued while cmd_alfull was high");
				if (cmd_idx >= n_cmds) begin
					report_protocol("command beyond the end of the job");
				end else begin
					exp_addr = job.base + `ADDR_W'(cmd_idx) * `ADDR_W'(`CACHELINE_BYTES);
					if (cmd_idx == n_cmds - 1)
						exp_real = job.size - `SIZE_W'(`CL_ELEMS) * (n_cmds - 1);
					else
						exp_real = `SIZE_W'(`CL_ELEMS);
					if (shared_mode) begin
						exp_op    = OP_READ_CL_S;
						exp_bytes = `BYTES_W'(`CACHELINE_BYTES);
					end else if (exp_real < `SIZE_W'(`CL_ELEMS)) begin
						exp_op    = OP_READ_PNA;
						exp_bytes = partial_bytes(exp_real);
					end else begin
						exp_op    = OP_READ_CL_NA;
						exp_bytes = `BYTES_W'(`CACHELINE_BYTES);
					end
					if (cmd.address != exp_addr)
						report_mismatch("cmd.address", exp_addr, cmd.address);
					if (cmd.real_size != exp_real)
						report_mismatch("cmd.real_size", 64'(exp_real), 64'(cmd.real_size));
					if (cmd.opcode != exp_op)
						report_mismatch("cmd.opcode", 64'(exp_op), 64'(cmd.opcode));
					if (cmd.size_bytes != exp_bytes)
						report_mismatch("cmd.size_bytes", 64'(exp_bytes), 64'(cmd.size_bytes));
				end
				cmd_idx = cmd_idx + 1;
				outstanding++;
			end
			if (resp.valid)
				outstanding--;
			if (outstanding > int'(batch_limit))
				report_protocol("more commands outstanding than batch_limit allows");
			// job completion
			if (job_ack && !ack_q) begin
				if (outstanding != 0)
					report_protocol("job_ack rose with responses still outstanding");
				if (cmd_idx != n_cmds)
					report_mismatch("command count", 64'(n_cmds), 64'(cmd_idx));
				if (words_done != job.size)
					report_mismatch("words_done", 64'(job.size), 64'(words_done));
			end
			if (job_ack && !req_q)
				report_protocol("job_ack high a cycle after job_req was low");
			if (ack_q && !job_ack && req_q)
				report_protocol("job_ack dropped while job_req was still high");
			req_q    = job_req;
			ack_q    = job_ack;
			alfull_q = cmd_alfull;
		end
	end

endmodule

// File: rtl/read_engine_top.sv
//////////////////////////////
// read engine top
// job FSM, batch counter and
// command generator for one read stream
//////////////////////////////

`timescale 1ns/1ps

`include "read_engine_defines.svh"

module read_engine_top (
	input  logic                         clock,
	input  logic                         rstn,
	input  logic                         job_req,
	input  read_engine_pkg::read_job_t   job,
	input  logic                         shared_mode,
	input  logic [`CNT_W-1:0]            batch_limit,
	input  logic                         cmd_alfull,
	input  read_engine_pkg::read_resp_t  resp,
	output logic                         job_ack,
	output read_engine_pkg::read_cmd_t   cmd,
	output logic [`SIZE_W-1:0]           words_done
);

	// FSM controls
	logic job_start;
	logic batch_clear;
	logic issue_en;

	// status back to the FSM
	logic issue_fire;
	logic remaining_empty;
	logic batch_full;
	logic drained;

	read_stream_fsm u_fsm (
		.clock           (clock),
		.rstn            (rstn),
		.job_req         (job_req),
		.batch_full      (batch_full),
		.drained         (drained),
		.remaining_empty (remaining_empty),
		.job_ack         (job_ack),
		.job_start       (job_start),
		.issue_en        (issue_en),
		.batch_clear     (batch_clear)
	);

	read_batch_counter u_counter (
		.clock       (clock),
		.rstn        (rstn),
		.job_start   (job_start),
		.batch_clear (batch_clear),
		.issue_fire  (issue_fire),
		.resp        (resp),
		.batch_limit (batch_limit),
		.batch_full  (batch_full),
		.drained     (drained),
		.words_done  (words_done)
	);

	read_command_gen u_cmd_gen (
		.clock           (clock),
		.rstn            (rstn),
		.job_start       (job_start),
		.job             (job),
		.shared_mode     (shared_mode),
		.issue_en        (issue_en),
		.cmd_alfull      (cmd_alfull),
		.issue_fire      (issue_fire),
		.remaining_empty (remaining_empty),
		.cmd             (cmd)
	);

endmodule

// File: rtl/read_command_gen.sv
//////////////////////////////
// read command generator
// holds the remaining job and turns it
// into cacheline read commands, one per
// cycle while enabled and not back-pressured
//////////////////////////////

`timescale 1ns/1ps

`include "read_engine_defines.svh"

module read_command_gen (
	input  logic                         clock,
	input  logic                         rstn,
	input  logic                         job_start,
	input  read_engine_pkg::read_job_t   job,
	input  logic                         shared_mode,
	input  logic                         issue_en,
	input  logic                         cmd_alfull,
	output logic                         issue_fire,
	output logic                         remaining_empty,
	output read_engine_pkg::read_cmd_t   cmd
);

	import read_engine_pkg::*;

	logic [`ADDR_W-1:0]  base_addr;
	logic [`ADDR_W-1:0]  offset;
	logic [`SIZE_W-1:0]  remaining;
	logic                mode_shared;
	logic [`SIZE_W-1:0]  chunk;
	logic                chunk_partial;

	logic                cmd_valid;
	read_opcode_e        cmd_opcode;
	logic [`ADDR_W-1:0]  cmd_addr;
	logic [`BYTES_W-1:0] cmd_bytes;
	logic [`SIZE_W-1:0]  cmd_real;

	// smallest power of two, at least 4, covering count elements
	function automatic logic [`BYTES_W-1:0] pna_bytes(input logic [`SIZE_W-1:0] count);
		logic [`SIZE_W-1:0]  bytes;
		logic [`BYTES_W-1:0] result;
		bytes  = count * `ELEM_BYTES;
		result = `BYTES_W'(`CACHELINE_BYTES);
		for (int i = 7; i >= 2; i--) begin
			if (bytes <= (`SIZE_W'(1) << i))
				result = `BYTES_W'(1) << i;
		end
		return result;
	endfunction

	assign issue_fire      = issue_en && !cmd_alfull;
	assign remaining_empty = (remaining == '0);

	// elements covered by the next command
	assign chunk = (remaining > `SIZE_W'(`CL_ELEMS)) ? `SIZE_W'(`CL_ELEMS) : remaining;
	assign chunk_partial = (chunk < `SIZE_W'(`CL_ELEMS));

//////////////////////////////
// job tracking
//////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			remaining <= '0;
			offset    <= '0;
		end else if (job_start) begin
			remaining <= job.size;
			offset    <= '0;
		end else if (issue_fire) begin
			remaining <= remaining - chunk;
			offset    <= offset + `ADDR_W'(`CACHELINE_BYTES);
		end
	end

	always_ff @(posedge clock) begin
		if (job_start) begin
			base_addr   <= job.base;
			mode_shared <= shared_mode;
		end
	end

//////////////////////////////
// command register
//////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			cmd_valid <= 1'b0;
		end else begin
			cmd_valid <= issue_fire;
		end
	end

	always_ff @(posedge clock) begin
		if (issue_fire) begin
			cmd_addr <= base_addr + offset;
			cmd_real <= chunk;
			if (mode_shared) begin
				cmd_opcode <= OP_READ_CL_S;
				cmd_bytes  <= `BYTES_W'(`CACHELINE_BYTES);
			end else if (chunk_partial) begin
				// partial last line
				cmd_opcode <= OP_READ_PNA;
				cmd_bytes  <= pna_bytes(chunk);
			end else begin
				cmd_opcode <= OP_READ_CL_NA;
				cmd_bytes  <= `BYTES_W'(`CACHELINE_BYTES);
			end
		end
	end

	always_comb begin
		cmd.valid      = cmd_valid;
		cmd.opcode     = cmd_opcode;
		cmd.address    = cmd_addr;
		cmd.size_bytes = cmd_bytes;
		cmd.real_size  = cmd_real;
	end

	// every command carries at least one element
	assert property (@(posedge clock) disable iff (!rstn)
		cmd.valid |-> (cmd.real_size != '0))
		else $error("command issued with zero real_size");

endmodule

// File: rtl/read_batch_counter.sv
//////////////////////////////
// read batch counter
// counts commands sent and responses
// returned per batch, flags a full or
// drained batch, totals done elements
//////////////////////////////

`timescale 1ns/1ps

`include "read_engine_defines.svh"

module read_batch_counter (
	input  logic                             clock,
	input  logic                             rstn,
	input  logic                             job_start,
	input  logic                             batch_clear,
	input  logic                             issue_fire,
	input  read_engine_pkg::read_resp_t      resp,
	input  logic [`CNT_W-1:0]                batch_limit,
	output logic                             batch_full,
	output logic                             drained,
	output logic [`SIZE_W-1:0]               words_done
);

	logic [`CNT_W-1:0] sent_cnt;
	logic [`CNT_W-1:0] resp_cnt;

//////////////////////////////
// batch counts
//////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			sent_cnt <= '0;
			resp_cnt <= '0;
		end else if (job_start || batch_clear) begin
			sent_cnt <= '0;
			resp_cnt <= '0;
		end else begin
			if (issue_fire)
				sent_cnt <= sent_cnt + 1'b1;
			if (resp.valid)
				resp_cnt <= resp_cnt + 1'b1;
		end
	end

	assign batch_full = (sent_cnt >= batch_limit);
	assign drained    = (resp_cnt == sent_cnt);

//////////////////////////////
// job total
//////////////////////////////

	// element count over the whole job
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			words_done <= '0;
		end else if (job_start) begin
			words_done <= '0;
		end else if (resp.valid) begin
			words_done <= words_done + resp.real_size;
		end
	end

	// no response without a command in flight
	assert property (@(posedge clock) disable iff (!rstn)
		resp_cnt <= sent_cnt)
		else $error("response count above sent count");

endmodule

// File: rtl/read_stream_fsm.sv
//////////////////////////////
// read stream FSM
// sequences one job through setup,
// request batches and drain waits,
// and answers job_req with job_ack
//////////////////////////////

`timescale 1ns/1ps

module read_stream_fsm (
	input  logic clock,
	input  logic rstn,
	input  logic job_req,
	input  logic batch_full,
	input  logic drained,
	input  logic remaining_empty,
	output logic job_ack,
	output logic job_start,
	output logic issue_en,
	output logic batch_clear
);

	import read_engine_pkg::*;

	read_state_e state;
	read_state_e next_state;

//////////////////////////////
// state register
//////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			state <= S_IDLE;
		end else begin
			state <= next_state;
		end
	end

	always_comb begin
		next_state = state;
		case (state)
			S_IDLE: begin
				if (job_req)
					next_state = S_SETUP;
			end
			S_SETUP: begin
				next_state = S_REQ;
			end
			S_REQ: begin
				// batch limit reached or job fully issued
				if (batch_full || remaining_empty)
					next_state = S_PENDING;
			end
			S_PENDING: begin
				if (drained) begin
					if (remaining_empty)
						next_state = S_DONE;
					else
						next_state = S_REQ;
				end
			end
			S_DONE: begin
				// hold ack until the requester lets go
				if (!job_req)
					next_state = S_IDLE;
			end
			default: begin
				next_state = S_IDLE;
			end
		endcase
	end

//////////////////////////////
// outputs
//////////////////////////////

	// load job and clear totals
	assign job_start = (state == S_SETUP);

	assign issue_en = (state == S_REQ) && !batch_full && !remaining_empty;

	// next batch starts once the current one drained
	assign batch_clear = (state == S_PENDING) && drained && !remaining_empty;

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			job_ack <= 1'b0;
		end else begin
			job_ack <= (next_state == S_DONE);
		end
	end

	// ack only once the job is fully issued and drained
	assert property (@(posedge clock) disable iff (!rstn)
		job_ack |-> (remaining_empty && drained))
		else $error("job_ack high before the job drained");

endmodule

// File: rtl/read_engine_pkg.sv
//////////////////////////////
// read engine types
// FSM states, command opcodes and the
// job, command and response structs
//////////////////////////////

`include "read_engine_defines.svh"

package read_engine_pkg;

	// engine FSM states
	typedef enum logic [2:0] {
		S_IDLE    = 3'd0,
		S_SETUP   = 3'd1,
		S_REQ     = 3'd2,
		S_PENDING = 3'd3,
		S_DONE    = 3'd4
	} read_state_e;

	// cacheline read opcodes
	typedef enum logic [1:0] {
		OP_READ_CL_S  = 2'd0,
		OP_READ_CL_NA = 2'd1,
		OP_READ_PNA   = 2'd2
	} read_opcode_e;

	// one read job, base byte address and element count
	typedef struct packed {
		logic [`ADDR_W-1:0] base;
		logic [`SIZE_W-1:0] size;
	} read_job_t;

	// one cacheline read command
	typedef struct packed {
		logic               valid;
		read_opcode_e       opcode;
		logic [`ADDR_W-1:0] address;
		logic [`BYTES_W-1:0] size_bytes;
		logic [`SIZE_W-1:0] real_size;
	} read_cmd_t;

	// response to one command
	typedef struct packed {
		logic               valid;
		logic [`SIZE_W-1:0] real_size;
	} read_resp_t;

endpackage

// File: rtl/read_engine_defines.svh
//////////////////////////////
// read engine widths and sizes
// fixed widths shared by the package
// and every read engine module
//////////////////////////////

`ifndef READ_ENGINE_DEFINES_SVH
`define READ_ENGINE_DEFINES_SVH

// byte address and element count widths
`define ADDR_W 64
`define SIZE_W 32

// batch and command counters
`define CNT_W 16

// cacheline geometry
`define CACHELINE_BYTES 128
`define ELEM_BYTES 4
`define CL_ELEMS 32

// byte size field of a command
`define BYTES_W 12

`endif
